//--- Makefile
SIM      := verilator
TOP      := tb_he
FILELIST := all.f
FLAGS    := --binary --timing --assert -j 0
LOG      := sim.log
FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
rtl/he_pixel_pkg.sv
rtl/he_job_pkg.sv
rtl/pixel_intake.sv
rtl/cdf_accumulate.sv
rtl/equalize_output.sv
rtl/he_top.sv
verif/he_checker.sv
verif/tb_he.sv

//--- rtl/cdf_accumulate.sv
`default_nettype none
`timescale 1ns/1ps

// stage 2: one running count per reference of frame pixels at or below it
module cdf_accumulate #(
	parameter int NUM_REF    = he_job_pkg::DEF_NUM_REF,
	parameter int FRAME_LOG2 = he_job_pkg::DEF_FRAME_LOG2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  he_pixel_pkg::pixel_t ref_pixels [NUM_REF],
	input  logic                 frame_valid,
	input  he_pixel_pkg::pixel_t frame_pixel,
	input  logic                 frame_last,
	output logic [FRAME_LOG2:0]  cdf_counts [NUM_REF],
	output logic                 cdf_valid
);

	// one extra bit so a full frame of hits fits
	localparam int CNT_W = FRAME_LOG2 + 1;

	logic [CNT_W-1:0] run_cnt  [NUM_REF];
	logic [CNT_W-1:0] cnt_next [NUM_REF];

	always_comb begin
		for (int i = 0; i < NUM_REF; i++)
			cnt_next[i] = run_cnt[i] + CNT_W'(frame_pixel <= ref_pixels[i]);
	end

	// --------------------
	// running counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REF; i++)
				run_cnt[i] <= '0;
			cdf_valid <= 1'b0;
		end else begin
			cdf_valid <= frame_valid && frame_last;
			if (frame_valid) begin
				for (int i = 0; i < NUM_REF; i++)
					run_cnt[i] <= frame_last ? '0 : cnt_next[i]; // clear for next job
			end
		end
	end

	// snapshot includes the last beat, held until the next job ends
	always_ff @(posedge clk) begin
		if (frame_valid && frame_last) begin
			for (int i = 0; i < NUM_REF; i++)
				cdf_counts[i] <= cnt_next[i];
		end
	end

endmodule

`default_nettype wire

//--- rtl/equalize_output.sv
`default_nettype none
`timescale 1ns/1ps

// stage 3: maps counts to grey levels and streams them in reference order
module equalize_output #(
	parameter int NUM_REF    = he_job_pkg::DEF_NUM_REF,
	parameter int FRAME_LOG2 = he_job_pkg::DEF_FRAME_LOG2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [FRAME_LOG2:0]  cdf_counts [NUM_REF],
	input  logic                 cdf_valid,
	output logic                 out_valid,
	output he_pixel_pkg::pixel_t out_image
);

	localparam int CNT_W = FRAME_LOG2 + 1;
	localparam int IDX_W = (NUM_REF > 1) ? $clog2(NUM_REF) : 1;
	localparam int PRD_W = CNT_W + 8;

	logic                 busy;
	logic [IDX_W-1:0]     idx;
	logic [IDX_W-1:0]     sel;
	logic [CNT_W-1:0]     sel_count;
	logic [PRD_W-1:0]     scaled;
	he_pixel_pkg::pixel_t grey;

	// --------------------
	// count * 255 / 2^FRAME_LOG2, never above 255
	always_comb begin
		sel       = cdf_valid ? '0 : idx;
		sel_count = cdf_counts[sel];
		scaled    = PRD_W'(sel_count) * PRD_W'(he_pixel_pkg::PIXEL_MAX);
		grey      = he_pixel_pkg::pixel_t'(scaled >> FRAME_LOG2);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_image <= '0;
			busy      <= 1'b0;
			idx       <= '0;
		end else if (cdf_valid) begin
			out_valid <= 1'b1; // result 0
			out_image <= grey;
			busy      <= (NUM_REF > 1);
			idx       <= IDX_W'(1);
		end else if (busy) begin
			out_valid <= 1'b1;
			out_image <= grey;
			idx       <= idx + 1'b1;
			if (idx == IDX_W'(NUM_REF - 1))
				busy <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_image <= '0; // idle bus reads zero
		end
	end

endmodule

`default_nettype wire

//--- rtl/he_job_pkg.sv
`default_nettype none

package he_job_pkg;

	// intake phase: references first, then the frame
	typedef enum logic {PH_REF = 1'b0, PH_FRAME = 1'b1} phase_t;

	localparam int DEF_NUM_REF    = 8;  // reference pixels per job
	localparam int DEF_FRAME_LOG2 = 10; // frame holds 1024 pixels

endpackage

`default_nettype wire

//--- rtl/he_pixel_pkg.sv
`default_nettype none

// pixel data shared by every stage

package he_pixel_pkg;

	// one grey level sample
	typedef logic [7:0] pixel_t;

	// full scale grey level, also the equalizer gain
	localparam int PIXEL_MAX = 255;

endpackage

`default_nettype wire

//--- rtl/he_top.sv
`default_nettype none
`timescale 1ns/1ps

// histogram equalization engine, three stage pipeline
module he_top #(
	parameter int NUM_REF    = he_job_pkg::DEF_NUM_REF,
	parameter int FRAME_LOG2 = he_job_pkg::DEF_FRAME_LOG2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  he_pixel_pkg::pixel_t in_image,
	output logic                 out_valid,
	output he_pixel_pkg::pixel_t out_image
);

	// --------------------
	// stage 1 -> stage 2
	he_pixel_pkg::pixel_t ref_pixels [NUM_REF];
	logic                 frame_valid;
	he_pixel_pkg::pixel_t frame_pixel;
	logic                 frame_last;

	// stage 2 -> stage 3
	logic [FRAME_LOG2:0]  cdf_counts [NUM_REF];
	logic                 cdf_valid;

	pixel_intake #(.NUM_REF(NUM_REF), .FRAME_LOG2(FRAME_LOG2)) pixel_intake_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_image    (in_image),
		.ref_pixels  (ref_pixels),
		.frame_valid (frame_valid),
		.frame_pixel (frame_pixel),
		.frame_last  (frame_last)
	);

	cdf_accumulate #(.NUM_REF(NUM_REF), .FRAME_LOG2(FRAME_LOG2)) cdf_accumulate_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.ref_pixels  (ref_pixels),
		.frame_valid (frame_valid),
		.frame_pixel (frame_pixel),
		.frame_last  (frame_last),
		.cdf_counts  (cdf_counts),
		.cdf_valid   (cdf_valid)
	);

	equalize_output #(.NUM_REF(NUM_REF), .FRAME_LOG2(FRAME_LOG2)) equalize_output_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cdf_counts (cdf_counts),
		.cdf_valid  (cdf_valid),
		.out_valid  (out_valid),
		.out_image  (out_image)
	);

endmodule

`default_nettype wire

//--- rtl/pixel_intake.sv
`default_nettype none
`timescale 1ns/1ps

// stage 1: splits a job into its reference pixels and its frame beats
module pixel_intake #(
	parameter int NUM_REF    = he_job_pkg::DEF_NUM_REF,
	parameter int FRAME_LOG2 = he_job_pkg::DEF_FRAME_LOG2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  he_pixel_pkg::pixel_t in_image,
	output he_pixel_pkg::pixel_t ref_pixels [NUM_REF],
	output logic                 frame_valid,
	output he_pixel_pkg::pixel_t frame_pixel,
	output logic                 frame_last
);

	localparam int                    REF_W     = (NUM_REF > 1) ? $clog2(NUM_REF) : 1;
	localparam logic [FRAME_LOG2-1:0] LAST_REF  = FRAME_LOG2'(NUM_REF - 1);
	localparam logic [FRAME_LOG2-1:0] LAST_BEAT = '1; // 2^FRAME_LOG2 - 1

	he_job_pkg::phase_t    phase;
	logic [FRAME_LOG2-1:0] beat_cnt; // shared by both phases

	// --------------------
	// phase and beat count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase       <= he_job_pkg::PH_REF;
			beat_cnt    <= '0;
			frame_valid <= 1'b0;
			frame_last  <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			frame_last  <= 1'b0;
			if (in_valid) begin
				case (phase)
					he_job_pkg::PH_REF: begin
						if (beat_cnt == LAST_REF) begin
							phase    <= he_job_pkg::PH_FRAME;
							beat_cnt <= '0;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
					he_job_pkg::PH_FRAME: begin
						frame_valid <= 1'b1;
						frame_last  <= (beat_cnt == LAST_BEAT);
						beat_cnt    <= beat_cnt + 1'b1; // wraps to zero after last beat
						if (beat_cnt == LAST_BEAT)
							phase <= he_job_pkg::PH_REF; // next job may start right away
					end
				endcase
			end
		end
	end

	// --------------------
	// payload
	always_ff @(posedge clk) begin
		if (in_valid && phase == he_job_pkg::PH_REF)
			ref_pixels[beat_cnt[REF_W-1:0]] <= in_image;
		if (in_valid && phase == he_job_pkg::PH_FRAME)
			frame_pixel <= in_image;
	end

endmodule

`default_nettype wire

//--- verif/he_checker.sv
`default_nettype none
`timescale 1ns/1ps

// output burst shape and intake phase rules
module he_checker #(
	parameter int NUM_REF = he_job_pkg::DEF_NUM_REF
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 out_valid,
	input he_pixel_pkg::pixel_t out_image,
	input he_job_pkg::phase_t   phase,
	input logic                 frame_last
);

	int unsigned error_count = 0;
	int          run_len; // out_valid cycles seen so far in this burst

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			run_len <= 0;
		else
			run_len <= out_valid ? run_len + 1 : 0;
	end

	burst_max_len: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> run_len < NUM_REF)
		else begin
			error_count++;
			$error("out_valid burst runs past %0d cycles", NUM_REF);
		end

	burst_full_len: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> run_len == NUM_REF)
		else begin
			error_count++;
			$error("out_valid burst ended after %0d cycles", run_len);
		end

	idle_image_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_image == '0)
		else begin
			error_count++;
			$error("out_image not zero while out_valid is low");
		end

	// frame_last is registered, so the phase that raised it is one cycle back
	last_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		frame_last |-> $past(phase) == he_job_pkg::PH_FRAME)
		else begin
			error_count++;
			$error("frame_last raised outside the frame phase");
		end

endmodule

bind pixel_intake he_checker #(.NUM_REF(NUM_REF)) intake_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (1'b0),
	.out_image  (8'h00),
	.phase      (phase),
	.frame_last (frame_last)
);

bind equalize_output he_checker #(.NUM_REF(NUM_REF)) output_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_image  (out_image),
	.phase      (he_job_pkg::PH_REF),
	.frame_last (1'b0)
);

`default_nettype wire

//--- verif/tb_he.sv
`default_nettype none
`timescale 1ns/1ps

module tb_he;

	localparam int NUM_REF    = he_job_pkg::DEF_NUM_REF;
	localparam int FRAME_LOG2 = he_job_pkg::DEF_FRAME_LOG2;
	localparam int FRAME_SIZE = 1 << FRAME_LOG2;

	localparam int JOB_RANDOM  = 0;
	localparam int JOB_FLAT    = 1; // every frame pixel the same level
	localparam int JOB_EXTREME = 2; // references 0 and 255 against a frame with no zeros

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	he_pixel_pkg::pixel_t in_image;
	logic                 out_valid;
	he_pixel_pkg::pixel_t out_image;

	he_pixel_pkg::pixel_t exp_q [$];   // expected grey levels in output order
	int                   start_q [$]; // edge count of each expected burst start
	logic [31:0]          lcg_state = 32'd46330;
	int                   edge_count = 0;
	int                   burst_len = 0;
	logic                 prev_valid = 1'b0;
	int value_errors = 0;
	int burst_errors = 0;
	int latency_errors = 0;
	int other_errors = 0;
	int assert_errors;
	int waited;

	he_top he_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_image  (in_image),
		.out_valid (out_valid),
		.out_image (out_image)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) edge_count <= edge_count + 1;

	function automatic int unsigned rand_below(input int unsigned n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % n;
	endfunction

	// --------------------
	// compare tasks
	task automatic compare_pixel(input he_pixel_pkg::pixel_t exp, input he_pixel_pkg::pixel_t act);
		if (act !== exp) begin
			$display("Fail out_image: expected 0x%02h, got 0x%02h", exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_burst(input int exp, input int act);
		if (act != exp) begin
			$display("Fail out_valid burst length: expected 0x%0h, got 0x%0h", exp, act);
			burst_errors++;
		end
	endtask

	task automatic verify_latency(input int exp, input int act);
		if (act != exp) begin
			$display("Fail out_valid start edge: expected 0x%0h, got 0x%0h", exp, act);
			latency_errors++;
		end
	endtask

	// --------------------
	// stimulus
	task automatic send_beat(input he_pixel_pkg::pixel_t value, input int gap_pct, input bit last);
		while (rand_below(100) < gap_pct) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			in_image = he_pixel_pkg::pixel_t'(rand_below(256)); // junk on idle cycles
		end
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		in_image = value;
		if (last)
			start_q.push_back(edge_count + 3); // sampled next edge, result two edges later
	endtask

	task automatic run_job(input int mode, input int gap_pct);
		he_pixel_pkg::pixel_t refs [NUM_REF];
		he_pixel_pkg::pixel_t frame [FRAME_SIZE];
		he_pixel_pkg::pixel_t level;
		int count;
		level = he_pixel_pkg::pixel_t'(rand_below(254) + 1);
		for (int i = 0; i < NUM_REF; i++)
			refs[i] = he_pixel_pkg::pixel_t'(rand_below(256));
		for (int j = 0; j < FRAME_SIZE; j++) begin
			if (mode == JOB_FLAT)
				frame[j] = level;
			else if (mode == JOB_EXTREME)
				frame[j] = he_pixel_pkg::pixel_t'(rand_below(255) + 1);
			else
				frame[j] = he_pixel_pkg::pixel_t'(rand_below(256));
		end
		if (mode == JOB_FLAT) begin
			refs[0] = 8'd255;
			refs[1] = level - 8'd1; // just below every frame pixel
			refs[2] = level;
		end else if (mode == JOB_EXTREME) begin
			refs[0] = 8'd0;
			refs[1] = 8'd255;
		end
		for (int i = 0; i < NUM_REF; i++)
			send_beat(refs[i], gap_pct, 1'b0);
		for (int j = 0; j < FRAME_SIZE; j++)
			send_beat(frame[j], gap_pct, j == FRAME_SIZE - 1);
		// model: cumulative count scaled to full grey range, rounded down
		for (int i = 0; i < NUM_REF; i++) begin
			count = 0;
			for (int j = 0; j < FRAME_SIZE; j++)
				if (frame[j] <= refs[i])
					count++;
			exp_q.push_back(he_pixel_pkg::pixel_t'((count * he_pixel_pkg::PIXEL_MAX) / FRAME_SIZE));
		end
	endtask

	// --------------------
	// monitor, sampled mid cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (!prev_valid) begin
					if (start_q.size() == 0) begin
						$display("out_valid rose before any job had finished");
						other_errors++;
					end else begin
						verify_latency(start_q.pop_front(), edge_count);
					end
				end
				if (exp_q.size() == 0) begin
					$display("out_valid high with no result expected");
					other_errors++;
				end else begin
					compare_pixel(exp_q.pop_front(), out_image);
				end
				burst_len++;
			end else if (prev_valid) begin
				compare_burst(NUM_REF, burst_len);
				burst_len = 0;
			end
			prev_valid = out_valid;
		end
	end

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_image = '0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (2) @(posedge clk);

		run_job(JOB_FLAT, 0);
		run_job(JOB_EXTREME, 25);
		for (int k = 0; k < 3; k++)
			run_job(JOB_RANDOM, 0); // back to back, bursts overlap the next intake
		run_job(JOB_RANDOM, 40);
		run_job(JOB_RANDOM, 10);
		@(posedge clk);
		#1 in_valid = 1'b0;

		waited = 0;
		while ((exp_q.size() != 0 || out_valid) && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0 || out_valid) begin
			$display("timed out waiting for the last output burst to finish");
			other_errors++;
		end
		repeat (2) @(posedge clk);

		assert_errors = he_top_i.pixel_intake_i.intake_chk.error_count
			+ he_top_i.equalize_output_i.output_chk.error_count;
		$display("errors: value %0d, burst %0d, latency %0d, other %0d, assertion %0d",
			value_errors, burst_errors, latency_errors, other_errors, assert_errors);
		if (value_errors + burst_errors + latency_errors + other_errors + assert_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
